// ==== build.f ====
gpio_pkg.sv
mtx_pkg.sv
mtx_ctrl.sv
tone_nco.sv
tone_combiner.sv
gpio_ctrl.sv
mtx_top.sv
mtx_assertions.sv
tb_clock.sv
mtx_tb.sv

// ==== gpio_ctrl.sv ====
module gpio_ctrl
  import gpio_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [GPIO_REG_WIDTH-1:0] fp_gpio_in,
  input  logic [GPIO_REG_WIDTH-1:0] gpio_out,
  output logic [GPIO_REG_WIDTH-1:0] fp_gpio_out,
  output logic [GPIO_REG_WIDTH-1:0] fp_gpio_ddr,
  output logic [GPIO_REG_WIDTH-1:0] gpio_in
);

  logic [GPIO_DIV_WIDTH-1:0] div_cnt;
  gpio_phase_t               gp_phase;
  logic [GPIO_REG_WIDTH-1:0] in_meta;
  logic [GPIO_REG_WIDTH-1:0] in_sync;

  // One update slot every GPIO_CLK_DIV cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt  <= '0;
      gp_phase <= GP_HOLD;
    end else if (div_cnt == GPIO_DIV_WIDTH'(GPIO_CLK_DIV - 1)) begin
      div_cnt  <= '0;
      gp_phase <= GP_UPDATE;
    end else begin
      div_cnt  <= div_cnt + 1'b1;
      gp_phase <= GP_HOLD;
    end
  end

  // Front-panel pins are asynchronous to clk
  always_ff @(posedge clk) begin
    in_meta <= fp_gpio_in;
    in_sync <= in_meta;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fp_gpio_out <= '0;
      fp_gpio_ddr <= GPIO_IO_DDR;
      gpio_in     <= '0;
    end else begin
      fp_gpio_ddr <= GPIO_IO_DDR;
      if (gp_phase == GP_UPDATE) begin
        fp_gpio_out <= gpio_out & GPIO_OUT_MASK;
        gpio_in     <= in_sync & GPIO_IN_MASK;
      end
    end
  end

endmodule

// ==== gpio_pkg.sv ====
package gpio_pkg;

  localparam int GPIO_REG_WIDTH = 12;
  localparam int GPIO_CLK_DIV   = 10;
  localparam int GPIO_DIV_WIDTH = $clog2(GPIO_CLK_DIV);

  localparam logic [GPIO_REG_WIDTH-1:0] SYNC_OUT_MASK = 12'h001;
  localparam logic [GPIO_REG_WIDTH-1:0] TX_OUT_MASK   = 12'h010;
  localparam logic [GPIO_REG_WIDTH-1:0] GPIO_OUT_MASK = SYNC_OUT_MASK | TX_OUT_MASK;
  localparam logic [GPIO_REG_WIDTH-1:0] GPIO_IN_MASK  = 12'h044; // Bit 2 is the arm inhibit

  // Pins driven by the controller, everything else stays an input
  localparam logic [GPIO_REG_WIDTH-1:0] GPIO_IO_DDR   = GPIO_OUT_MASK;

  typedef enum logic {
    GP_HOLD,
    GP_UPDATE
  } gpio_phase_t;

endpackage

// ==== mtx_assertions.sv ====
module mtx_assertions (
  input logic clk,
  input logic reset,
  input logic arm_req,
  input logic arm_ack,
  input logic lane_en,
  input logic out_sel
);
  timeunit 1ns;
  timeprecision 1ps;

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(arm_ack) |-> arm_req)
    else $error("arm_ack rose while arm_req was low");

  // Gap select lines up with lane outputs that lag lane_en by two cycles
  lanes_or_gap: assert property (@(posedge clk) disable iff (reset)
    !($past(lane_en, 2) && out_sel))
    else $error("lane_en and out_sel high together");

  // Four-phase rule, the host lets go first
  ack_falls_late: assert property (@(posedge clk) disable iff (reset)
    $fell(arm_ack) |-> !$past(arm_req))
    else $error("arm_ack fell before arm_req was released");

endmodule

bind mtx_ctrl mtx_assertions u_assertions (
  .clk     (clk),
  .reset   (reset),
  .arm_req (arm_req),
  .arm_ack (arm_ack),
  .lane_en (lane_en),
  .out_sel (out_sel)
);

// ==== mtx_ctrl.sv ====
module mtx_ctrl
  import mtx_pkg::*, gpio_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      arm_req,
  input  logic [GPIO_REG_WIDTH-1:0] gpio_in,
  output logic                      arm_ack,
  output logic                      lane_srst,
  output logic                      lane_en,
  output logic                      out_sel,
  output logic                      tx_trig,
  output logic [GPIO_REG_WIDTH-1:0] gpio_out
);

  mtx_state_t           state;
  logic [CNT_WIDTH-1:0] cnt;
  logic [CNT_WIDTH-1:0] cnt_last;
  logic                 arm_inhibit;
  logic                 in_sync;
  logic [1:0]           gap_pipe;
  logic [1:0]           trig_pipe;

  assign arm_inhibit = gpio_in[2]; // Front-panel inhibit holds the sequencer in idle
  assign in_sync     = (state == ST_SYNC1) || (state == ST_SYNC2);
  assign lane_en     = in_sync || (state == ST_TX);

  always_comb begin
    case (state)
      ST_SYNC1, ST_SYNC2: cnt_last = CNT_WIDTH'(SYNC_LEN - 1);
      ST_GAP:             cnt_last = CNT_WIDTH'(GAP_LEN - 1);
      default:            cnt_last = CNT_WIDTH'(BURST_LEN - 1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      cnt       <= '0;
      arm_ack   <= 1'b0;
      lane_srst <= 1'b0;
    end else begin
      lane_srst <= 1'b0;
      case (state)
        ST_IDLE: begin
          cnt <= '0;
          if (arm_req && !arm_ack && !arm_inhibit) begin
            state     <= ST_SYNC1;
            lane_srst <= 1'b1; // Restart every lane phase with the preamble
          end
        end
        ST_DONE: begin
          if (!arm_req) begin
            arm_ack <= 1'b0;
            state   <= ST_IDLE;
          end
        end
        default: begin
          if (cnt == cnt_last) begin
            cnt <= '0;
            case (state)
              ST_SYNC1: state <= ST_SYNC2;
              ST_SYNC2: state <= ST_GAP;
              ST_GAP:   state <= ST_TX;
              default: begin
                state   <= ST_DONE;
                arm_ack <= 1'b1; // Burst finished, host may release arm_req
              end
            endcase
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Lane lookup takes two cycles, so the gap and trigger windows lag the state by two
  always_ff @(posedge clk) begin
    if (reset) begin
      gap_pipe  <= '0;
      trig_pipe <= '0;
    end else begin
      gap_pipe  <= {gap_pipe[0], state == ST_GAP};
      trig_pipe <= {trig_pipe[0], state == ST_TX};
    end
  end

  // The tail of the delayed gap overlaps the new burst, the lanes are still zero there
  assign out_sel = gap_pipe[1] && !lane_en;
  assign tx_trig = trig_pipe[1];

  always_comb begin
    gpio_out = '0;
    if (in_sync) begin
      gpio_out = gpio_out | SYNC_OUT_MASK;
    end
    if (!out_sel && (state != ST_IDLE)) begin
      gpio_out = gpio_out | TX_OUT_MASK;
    end
  end

endmodule

// ==== mtx_pkg.sv ====
package mtx_pkg;

  localparam int DATA_WIDTH     = 16;
  localparam int PHASE_WIDTH    = 24;
  localparam int N_TONES        = 4;
  localparam int SUM_WIDTH      = DATA_WIDTH + $clog2(N_TONES); // Headroom for the lane sum
  localparam int LUT_ADDR_WIDTH = 6;
  localparam int QTR_STEPS      = 2 ** (LUT_ADDR_WIDTH - 2);

  localparam logic [PHASE_WIDTH-1:0] TONE_INC      = 24'h040000; // Lane k steps by k+1 times this
  localparam logic [PHASE_WIDTH-1:0] LANE_PH_SHIFT = 24'h100000;
  localparam logic [PHASE_WIDTH-1:0] START_PH      = 24'h000000;

  localparam int SYNC_LEN  = 16;
  localparam int GAP_LEN   = 8;
  localparam int BURST_LEN = 64;
  localparam int CNT_WIDTH = $clog2(BURST_LEN);

  // First quarter of a sine at 8191 full scale, four lanes still fit in 16 bits
  localparam logic [DATA_WIDTH-1:0] SINE_QTR [0:QTR_STEPS] = '{
    16'd0,
    16'd803,
    16'd1598,
    16'd2378,
    16'd3135,
    16'd3861,
    16'd4551,
    16'd5196,
    16'd5792,
    16'd6332,
    16'd6811,
    16'd7224,
    16'd7567,
    16'd7838,
    16'd8034,
    16'd8152,
    16'd8191
  };

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SYNC1,
    ST_SYNC2,
    ST_GAP,
    ST_TX,
    ST_DONE
  } mtx_state_t;

endpackage

// ==== mtx_tb.sv ====
module mtx_tb
  import mtx_pkg::*, gpio_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_VEC        = 13;
  localparam int FIELDS       = 6;
  localparam int N_BURSTS     = 3;
  localparam int VALID_LEN    = 2 * SYNC_LEN + BURST_LEN; // Preamble and burst both carry samples
  localparam int INHIBIT_HOLD = 100;
  localparam int SETTLE       = 2 * GPIO_CLK_DIV;
  localparam int CYCLE_LIMIT  = (2 * SYNC_LEN + GAP_LEN + BURST_LEN + 50) * N_BURSTS
                                + INHIBIT_HOLD + 3 * GPIO_CLK_DIV + 50;

  logic                      clk;
  logic                      reset;
  logic                      arm_req;
  logic [GPIO_REG_WIDTH-1:0] fp_gpio_in;
  logic                      arm_ack;
  logic [DATA_WIDTH-1:0]     itx;
  logic [DATA_WIDTH-1:0]     qtx;
  logic                      tx_valid;
  logic                      tx_trig;
  logic [GPIO_REG_WIDTH-1:0] fp_gpio_out;
  logic [GPIO_REG_WIDTH-1:0] fp_gpio_ddr;

  logic [31:0]               vec_mem [0:N_VEC*FIELDS-1];
  logic [31:0]               rng;
  int                        errors;
  int                        test_errors;
  int                        tests_run;
  int                        tests_failed;
  int                        cycle_count;
  int                        hold_bad;
  bit                        capturing;
  int                        valid_idx;
  int                        low_run;
  int                        gap_runs;
  int                        gap_seen;
  int                        gap_nonzero;
  int                        trig_count;
  int                        trig_cyc;
  int                        burst_cyc;
  logic [DATA_WIDTH-1:0]     itx_cap [0:VALID_LEN-1];
  logic [DATA_WIDTH-1:0]     qtx_cap [0:VALID_LEN-1];
  logic [GPIO_REG_WIDTH-1:0] last_gpio;
  logic [GPIO_REG_WIDTH-1:0] gpio_vals [$];
  int                        gpio_cyc [$];
  logic [GPIO_REG_WIDTH-1:0] ddr_word;
  logic [GPIO_REG_WIDTH-1:0] sync_word;
  logic [GPIO_REG_WIDTH-1:0] tx_word;
  logic [GPIO_REG_WIDTH-1:0] inhibit_word;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  mtx_top UUT (
    .clk         (clk),
    .reset       (reset),
    .arm_req     (arm_req),
    .fp_gpio_in  (fp_gpio_in),
    .arm_ack     (arm_ack),
    .itx         (itx),
    .qtx         (qtx),
    .tx_valid    (tx_valid),
    .tx_trig     (tx_trig),
    .fp_gpio_out (fp_gpio_out),
    .fp_gpio_ddr (fp_gpio_ddr)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] vec_field(input int v, input int f);
    return vec_mem[v*FIELDS+f];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic end_test(input int id, input string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("test %0d %s: FAIL", id, name);
    end else begin
      $display("test %0d %s: ok", id, name);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // Sample on the falling edge where every output is settled
  always @(negedge clk) begin
    if (capturing) begin
      if (tx_trig) begin
        if (trig_count == 0) trig_cyc = cycle_count;
        trig_count++;
      end
      if (tx_valid) begin
        if (valid_idx < VALID_LEN) begin
          itx_cap[valid_idx] = itx;
          qtx_cap[valid_idx] = qtx;
        end
        if (valid_idx == 2 * SYNC_LEN) burst_cyc = cycle_count;
        if ((valid_idx > 0) && (low_run > 0)) begin
          gap_runs++;
          gap_seen = low_run;
        end
        low_run = 0;
        valid_idx++;
      end else if (valid_idx > 0) begin
        low_run++;
        if ((itx != '0) || (qtx != '0)) gap_nonzero++;
      end
      if (fp_gpio_out != last_gpio) begin
        gpio_vals.push_back(fp_gpio_out);
        gpio_cyc.push_back(cycle_count);
        last_gpio = fp_gpio_out;
      end
    end
  end

  task automatic start_capture();
    valid_idx   = 0;
    low_run     = 0;
    gap_runs    = 0;
    gap_seen    = 0;
    gap_nonzero = 0;
    trig_count  = 0;
    trig_cyc    = -1;
    burst_cyc   = -1;
    gpio_vals.delete();
    gpio_cyc.delete();
    last_gpio   = fp_gpio_out;
    capturing   = 1'b1;
  endtask

  // Wait for the ack, hold the request a random while, then release
  task automatic finish_burst();
    int delay;
    while (!arm_ack) @(negedge clk);
    rng   = xorshift(rng);
    delay = int'(rng % 32'd16);
    repeat (delay) begin
      @(negedge clk);
      check_value("arm_ack", 32'(arm_ack), 32'd1);
    end
    @(posedge clk);
    arm_req <= 1'b0;
    while (arm_ack) @(negedge clk);
    repeat (SETTLE) @(negedge clk);
    capturing = 1'b0;
  endtask

  task automatic check_samples();
    int n;
    check_value("valid sample count", valid_idx, VALID_LEN);
    for (int v = 0; v < N_VEC; v++) begin
      if (vec_field(v, 0) == 32'd3) begin
        n = int'(vec_field(v, 2));
        if (n < valid_idx) begin
          check_value($sformatf("itx[%0d]", n), 32'(itx_cap[n]), vec_field(v, 3));
          check_value($sformatf("qtx[%0d]", n), 32'(qtx_cap[n]), vec_field(v, 4));
        end
      end
    end
  endtask

  // The trigger window lags the state by two cycles and leads tx_valid by one
  task automatic check_trigger();
    check_value("tx_trig cycles", trig_count, BURST_LEN);
    check_value("tx_trig lead", burst_cyc - trig_cyc, 1);
  endtask

  task automatic check_gap();
    check_value("gap count", gap_runs, 1);
    check_value("gap length", gap_seen, GAP_LEN);
    if (gap_nonzero != 0) report_failure("itx or qtx nonzero while tx_valid was low");
  endtask

  task automatic check_gpio();
    int  first_nz;
    int  last_nz;
    bit  tx_seen;
    first_nz = -1;
    last_nz  = -1;
    tx_seen  = 1'b0;
    foreach (gpio_vals[i]) begin
      if ((i > 0) && (((gpio_cyc[i] - gpio_cyc[i-1]) % GPIO_CLK_DIV) != 0)) begin
        report_failure("fp_gpio_out changed between divider ticks");
      end
      if (gpio_vals[i] != '0) begin
        if (first_nz < 0) first_nz = i;
        last_nz = i;
        if (gpio_vals[i] == tx_word) tx_seen = 1'b1;
        else if (tx_seen && gpio_vals[i][0]) report_failure("sync bit came back after tx bit");
      end
    end
    if (first_nz < 0) begin
      report_failure("no marker bits appeared on fp_gpio_out");
    end else begin
      check_value("fp_gpio_out first", 32'(gpio_vals[first_nz]), 32'(sync_word));
      check_value("fp_gpio_out last", 32'(gpio_vals[last_nz]), 32'(tx_word));
    end
    check_value("fp_gpio_out idle", 32'(fp_gpio_out), 32'd0);
  endtask

  initial begin
    arm_req     <= 1'b0;
    fp_gpio_in  <= '0;
    rng          = 32'hc8ed;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hold_bad     = 0;
    capturing    = 1'b0;
    $readmemh("mtx_vectors.txt", vec_mem);
    sync_word = '1;
    for (int v = 0; v < N_VEC; v++) begin
      case (vec_field(v, 0))
        32'd1: ddr_word = GPIO_REG_WIDTH'(vec_field(v, 5));
        32'd5: begin
          if (sync_word == '1) sync_word = GPIO_REG_WIDTH'(vec_field(v, 5));
          else tx_word = GPIO_REG_WIDTH'(vec_field(v, 5));
        end
        32'd6: inhibit_word = GPIO_REG_WIDTH'(vec_field(v, 1));
        default: ;
      endcase
    end

    @(negedge clk);
    while (reset) @(negedge clk);
    begin_test();
    check_value("tx_valid", 32'(tx_valid), 32'd0);
    check_value("arm_ack", 32'(arm_ack), 32'd0);
    check_value("fp_gpio_out", 32'(fp_gpio_out), 32'd0);
    check_value("fp_gpio_ddr", 32'(fp_gpio_ddr), 32'(ddr_word));
    end_test(1, "reset values");

    start_capture();
    @(posedge clk);
    arm_req <= 1'b1;
    finish_burst();
    begin_test();
    check_samples();
    check_trigger();
    end_test(3, "burst samples");
    begin_test();
    check_gap();
    end_test(4, "gap between preamble and burst");
    begin_test();
    check_gpio();
    end_test(5, "front-panel markers");

    begin_test();
    start_capture();
    @(posedge clk);
    arm_req <= 1'b1;
    finish_burst();
    check_samples();
    check_gap();
    end_test(2, "four-phase handshake and second burst");

    begin_test();
    start_capture();
    @(posedge clk);
    fp_gpio_in <= inhibit_word;
    repeat (3 * GPIO_CLK_DIV) @(posedge clk); // Inhibit must reach gpio_in before arming
    arm_req <= 1'b1;
    repeat (INHIBIT_HOLD) begin
      @(negedge clk);
      if (arm_ack || tx_valid) hold_bad++;
    end
    if (hold_bad != 0) report_failure("burst started while the arm inhibit was high");
    @(posedge clk);
    fp_gpio_in <= '0;
    finish_burst();
    check_samples();
    end_test(6, "arm inhibit");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== mtx_top.sv ====
module mtx_top
  import mtx_pkg::*, gpio_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      arm_req,
  input  logic [GPIO_REG_WIDTH-1:0] fp_gpio_in,
  output logic                      arm_ack,
  output logic [DATA_WIDTH-1:0]     itx,
  output logic [DATA_WIDTH-1:0]     qtx,
  output logic                      tx_valid,
  output logic                      tx_trig,
  output logic [GPIO_REG_WIDTH-1:0] fp_gpio_out,
  output logic [GPIO_REG_WIDTH-1:0] fp_gpio_ddr
);

  logic                          lane_srst;
  logic                          lane_en;
  logic                          out_sel;
  logic [GPIO_REG_WIDTH-1:0]     gpio_out;
  logic [GPIO_REG_WIDTH-1:0]     gpio_in;
  logic [N_TONES*DATA_WIDTH-1:0] sin_bus;
  logic [N_TONES*DATA_WIDTH-1:0] cos_bus;

  mtx_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .arm_req   (arm_req),
    .gpio_in   (gpio_in),
    .arm_ack   (arm_ack),
    .lane_srst (lane_srst),
    .lane_en   (lane_en),
    .out_sel   (out_sel),
    .tx_trig   (tx_trig),
    .gpio_out  (gpio_out)
  );

  for (genvar k = 0; k < N_TONES; k++) begin : g_lane
    tone_nco #(.LANE(k)) u_nco (
      .clk   (clk),
      .reset (reset),
      .srst  (lane_srst),
      .en    (lane_en),
      .sin   (sin_bus[k*DATA_WIDTH +: DATA_WIDTH]),
      .cos   (cos_bus[k*DATA_WIDTH +: DATA_WIDTH])
    );
  end

  tone_combiner u_combiner (
    .clk      (clk),
    .reset    (reset),
    .sin_bus  (sin_bus),
    .cos_bus  (cos_bus),
    .out_sel  (out_sel),
    .itx      (itx),
    .qtx      (qtx),
    .tx_valid (tx_valid)
  );

  gpio_ctrl u_gpio (
    .clk         (clk),
    .reset       (reset),
    .fp_gpio_in  (fp_gpio_in),
    .gpio_out    (gpio_out),
    .fp_gpio_out (fp_gpio_out),
    .fp_gpio_ddr (fp_gpio_ddr),
    .gpio_in     (gpio_in)
  );

endmodule

// ==== mtx_vectors.txt ====
// test fp_gpio_in index itx qtx fp_gpio, all hex, index counts from the first tx_valid
// test 1 gives fp_gpio_ddr in the last column, test 5 gives the marker words in order
1 000 00 0000 0000 011
3 000 00 606D 406E 000
3 000 01 4988 5121 000
3 000 02 3001 59CF 000
3 000 08 DE23 16A0 000
3 000 10 0550 1AAF 000
3 000 1F F9F2 10EC 000
3 000 20 F32F 132E 000
3 000 40 606D 406E 000
3 000 5F F9F2 10EC 000
5 000 00 0000 0000 011
5 000 00 0000 0000 010
6 004 00 0000 0000 000

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mtx_tb -f build.f -o mtx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/mtx_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
  exit 0
fi
exit 1

// ==== tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== tone_combiner.sv ====
module tone_combiner
  import mtx_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic [N_TONES*DATA_WIDTH-1:0] sin_bus,
  input  logic [N_TONES*DATA_WIDTH-1:0] cos_bus,
  input  logic                          out_sel,
  output logic [DATA_WIDTH-1:0]         itx,
  output logic [DATA_WIDTH-1:0]         qtx,
  output logic                          tx_valid
);

  logic signed [SUM_WIDTH-1:0] sum_i;
  logic signed [SUM_WIDTH-1:0] sum_q;
  logic                        lanes_idle;
  logic                        mute;

  function automatic logic [DATA_WIDTH-1:0] saturate(input logic signed [SUM_WIDTH-1:0] value);
    logic [SUM_WIDTH-DATA_WIDTH:0] top;
    top = value[SUM_WIDTH-1:DATA_WIDTH-1];
    if ((top == '0) || (top == '1)) begin
      saturate = value[DATA_WIDTH-1:0];
    end else if (value[SUM_WIDTH-1]) begin
      saturate = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    end else begin
      saturate = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    end
  endfunction

  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int k = 0; k < N_TONES; k++) begin
      sum_i = sum_i + SUM_WIDTH'($signed(cos_bus[k*DATA_WIDTH +: DATA_WIDTH]));
      sum_q = sum_q + SUM_WIDTH'($signed(sin_bus[k*DATA_WIDTH +: DATA_WIDTH]));
    end
  end

  // A running lane never has sine and cosine both zero
  assign lanes_idle = (sin_bus == '0) && (cos_bus == '0);
  assign mute       = out_sel || lanes_idle;

  always_ff @(posedge clk) begin
    itx <= mute ? '0 : saturate(sum_i);
    qtx <= mute ? '0 : saturate(sum_q);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= !mute;
    end
  end

endmodule

// ==== tone_nco.sv ====
module tone_nco
  import mtx_pkg::*;
#(
  parameter int LANE = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  srst,
  input  logic                  en,
  output logic [DATA_WIDTH-1:0] sin,
  output logic [DATA_WIDTH-1:0] cos
);

  localparam logic [PHASE_WIDTH-1:0] PH_INC   = PHASE_WIDTH'(TONE_INC * (LANE + 1));
  localparam logic [PHASE_WIDTH-1:0] PH_START = PHASE_WIDTH'(START_PH + LANE * LANE_PH_SHIFT);

  logic [PHASE_WIDTH-1:0]    phase;
  logic                      en_q;
  logic [LUT_ADDR_WIDTH-1:0] sin_addr;
  logic [LUT_ADDR_WIDTH-1:0] cos_addr;

  // Top two address bits pick the quadrant, the rest walk the quarter table
  function automatic logic [DATA_WIDTH-1:0] quarter_lookup(
    input logic [LUT_ADDR_WIDTH-1:0] addr
  );
    int unsigned              idx;
    int unsigned              pos;
    logic [DATA_WIDTH-1:0]    mag;
    idx = addr[LUT_ADDR_WIDTH-3:0];
    pos = addr[LUT_ADDR_WIDTH-2] ? QTR_STEPS - idx : idx; // Falling half of each lobe
    mag = SINE_QTR[pos];
    quarter_lookup = addr[LUT_ADDR_WIDTH-1] ? -mag : mag;
  endfunction

  assign sin_addr = phase[PHASE_WIDTH-1 -: LUT_ADDR_WIDTH];
  assign cos_addr = sin_addr + LUT_ADDR_WIDTH'(QTR_STEPS); // Quarter turn ahead

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_START;
      en_q  <= 1'b0;
    end else begin
      en_q <= en;
      if (srst) begin
        phase <= PH_START;
      end else if (en) begin
        phase <= phase + PH_INC;
      end
    end
  end

  // A stopped lane drives zero, the combiner reads that as idle
  always_ff @(posedge clk) begin
    if (en_q) begin
      sin <= quarter_lookup(sin_addr);
      cos <= quarter_lookup(cos_addr);
    end else begin
      sin <= '0;
      cos <= '0;
    end
  end

endmodule
